/* logic/stream_pkg.sv */
// Stream data path types shared by the packet checker, drop FIFO and top level

package stream_pkg;

  // Width of one data word on the stream
  parameter int DATA_W = 32;

  // One beat as seen on the external input and output ports
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } stream_beat_t;

  // Beat leaving the checker, with the verdict on the last beat
  typedef struct packed {
    stream_beat_t beat;
    logic         err;
  } chk_beat_t;

  // Per-packet outcome pulses, one cycle wide
  // At most one of them is set, and only when a last beat is taken
  typedef struct packed {
    logic good;
    logic bad;
  } pkt_evt_t;

endpackage : stream_pkg

/* logic/csr_pkg.sv */
// APB bus structs and register map of the packet filter configuration block

package csr_pkg;

  parameter int APB_ADDR_W = 8;
  parameter int APB_DATA_W = 32;

  // Requester side of the APB port
  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  // Completer side of the APB port
  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

  // Register offsets
  parameter logic [APB_ADDR_W-1:0] REG_CTRL     = 8'h00;
  parameter logic [APB_ADDR_W-1:0] REG_GOOD_CNT = 8'h04;
  parameter logic [APB_ADDR_W-1:0] REG_DROP_CNT = 8'h08;

  // Control register fields
  parameter int CTRL_CHECK_EN_BIT = 0;
  // Self-clearing, reads back as zero
  parameter int CTRL_CLEAR_BIT    = 1;

endpackage : csr_pkg

/* logic/pkt_check.sv */
// Running-XOR checksum checker, one register stage in front of the drop FIFO

`timescale 1ns/100ps

module pkt_check #(
  parameter int DATA_W = stream_pkg::DATA_W
) (
  input  logic                     clk,
  input  logic                     i_arst_n,
  input  logic                     i_clear,
  input  logic                     i_check_en,
  input  logic                     i_valid,
  input  stream_pkg::stream_beat_t i_beat,
  output logic                     o_ready,
  output stream_pkg::chk_beat_t    o_beat,
  output logic                     o_valid,
  input  logic                     i_ready,
  output stream_pkg::pkt_evt_t     o_evt
);

  logic [DATA_W-1:0] xor_acc;
  logic [DATA_W-1:0] xor_next;
  logic              accept;
  logic              err_now;

  // Register is free when empty or being drained this cycle
  assign o_ready = i_ready | ~o_valid;
  assign accept  = i_valid & o_ready;

  assign xor_next = xor_acc ^ i_beat.data;

  // Only meaningful on a last beat: the whole packet must XOR to zero
  assign err_now = i_check_en & (|xor_next);

  assign o_evt.good = accept & i_beat.last & ~err_now;
  assign o_evt.bad  = accept & i_beat.last & err_now;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      xor_acc <= '0;
      o_valid <= 1'b0;
    end else if (i_clear) begin
      xor_acc <= '0;
      o_valid <= 1'b0;
    end else begin
      if (accept) begin
        // Restart the sum at each packet boundary
        xor_acc <= i_beat.last ? '0 : xor_next;
      end
      if (o_ready) begin
        o_valid <= i_valid;
      end
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (accept) begin
      o_beat.beat <= i_beat;
      o_beat.err  <= i_beat.last & err_now;
    end
  end

endmodule : pkt_check

/* logic/pkt_drop_fifo.sv */
// Store-and-forward packet FIFO that discards packets flagged bad on their last beat

`timescale 1ns/100ps

module pkt_drop_fifo #(
  parameter int DATA_W        = stream_pkg::DATA_W,
  parameter int MAX_PKT_BEATS = 16
) (
  input  logic                     clk,
  input  logic                     i_arst_n,
  input  logic                     i_clear,
  input  logic                     i_valid,
  input  stream_pkg::chk_beat_t    i_beat,
  output logic                     o_ready,
  output stream_pkg::stream_beat_t o_beat,
  output logic                     o_valid,
  input  logic                     i_ready
);

  // One slot stays free to tell full from empty, so DEPTH-1 >= MAX_PKT_BEATS
  localparam int AW    = $clog2(MAX_PKT_BEATS + 1);
  localparam int DEPTH = 1 << AW;

  // Each word holds {last, data}
  logic [DATA_W:0]   mem [DEPTH];

  logic [AW-1:0]     wr_ptr;
  logic [AW-1:0]     wr_ptr_inc;
  logic [AW-1:0]     good_end;
  logic [AW-1:0]     rd_ptr;
  logic [AW-1:0]     in_pkt_cnt;
  logic [AW-1:0]     out_pkt_cnt;
  logic              full;
  logic              wr_fire;
  logic              pkt_avail;
  logic              rd_load;
  logic [DATA_W:0]   rd_word;

  assign wr_ptr_inc = wr_ptr + 1'b1;
  assign full       = (wr_ptr_inc == rd_ptr);
  assign o_ready    = ~full;
  assign wr_fire    = i_valid & ~full;

  // A complete good packet sits in memory whenever the counts differ
  assign pkt_avail  = (in_pkt_cnt != out_pkt_cnt);
  assign rd_load    = pkt_avail & (~o_valid | i_ready);
  assign rd_word    = mem[rd_ptr];

  // Write side with rewind
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr     <= '0;
      good_end   <= '0;
      in_pkt_cnt <= '0;
    end else if (i_clear) begin
      wr_ptr     <= '0;
      good_end   <= '0;
      in_pkt_cnt <= '0;
    end else if (wr_fire) begin
      if (!i_beat.beat.last) begin
        wr_ptr <= wr_ptr_inc;
      end else if (i_beat.err) begin
        // Throw away everything written since the last good packet
        wr_ptr <= good_end;
      end else begin
        wr_ptr     <= wr_ptr_inc;
        good_end   <= wr_ptr_inc;
        in_pkt_cnt <= in_pkt_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= {i_beat.beat.last, i_beat.beat.data};
    end
  end

  // Read side, one beat per cycle into the output register
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_ptr      <= '0;
      out_pkt_cnt <= '0;
      o_valid     <= 1'b0;
    end else if (i_clear) begin
      rd_ptr      <= '0;
      out_pkt_cnt <= '0;
      o_valid     <= 1'b0;
    end else begin
      if (rd_load) begin
        rd_ptr  <= rd_ptr + 1'b1;
        o_valid <= 1'b1;
        if (rd_word[DATA_W]) begin
          out_pkt_cnt <= out_pkt_cnt + 1'b1;
        end
      end else if (i_ready) begin
        o_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_load) begin
      o_beat.data <= rd_word[DATA_W-1:0];
      o_beat.last <= rd_word[DATA_W];
    end
  end

endmodule : pkt_drop_fifo

/* logic/stream_flop2.sv */
// Two-entry registered stream buffer for any payload type, cuts the ready path

`timescale 1ns/100ps

module stream_flop2 #(
  parameter type T_PAYLOAD = logic [31:0]
) (
  input  logic     clk,
  input  logic     i_arst_n,
  input  logic     i_clear,
  input  logic     i_valid,
  input  T_PAYLOAD i_data,
  output logic     o_ready,
  output T_PAYLOAD o_data,
  output logic     o_valid,
  input  logic     i_ready
);

  // Skid entry, filled only while the head entry is stalled
  T_PAYLOAD skid_data;
  logic     skid_valid;
  logic     head_free;

  // Ready comes from local state only
  assign o_ready   = ~skid_valid;
  assign head_free = ~o_valid | i_ready;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (i_clear) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (head_free) begin
      // Skid entry drains first to keep order
      o_valid    <= skid_valid | i_valid;
      skid_valid <= 1'b0;
    end else if (i_valid && !skid_valid) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (head_free) begin
      o_data <= skid_valid ? skid_data : i_data;
    end else if (!skid_valid) begin
      skid_data <= i_data;
    end
  end

endmodule : stream_flop2

/* logic/pkt_stats_csr.sv */
// APB register block with check enable, clear pulse and good/dropped packet counters

`timescale 1ns/100ps

module pkt_stats_csr (
  input  logic                 clk,
  input  logic                 i_arst_n,
  input  csr_pkg::apb_req_t    i_apb,
  output csr_pkg::apb_rsp_t    o_apb,
  input  stream_pkg::pkt_evt_t i_evt,
  output logic                 o_check_en,
  output logic                 o_clear
);

  import csr_pkg::*;

  logic                  access;
  logic                  addr_hit;
  logic                  ctrl_wr;
  logic [APB_DATA_W-1:0] good_cnt;
  logic [APB_DATA_W-1:0] drop_cnt;

  assign access   = i_apb.psel & i_apb.penable;
  assign addr_hit = (i_apb.paddr == REG_CTRL) ||
                    (i_apb.paddr == REG_GOOD_CNT) ||
                    (i_apb.paddr == REG_DROP_CNT);
  assign ctrl_wr  = access & i_apb.pwrite & (i_apb.paddr == REG_CTRL);

  // No wait states
  assign o_apb.pready  = 1'b1;
  assign o_apb.pslverr = access & ~addr_hit;

  always_comb begin
    o_apb.prdata = '0;
    case (i_apb.paddr)
      REG_CTRL:     o_apb.prdata[CTRL_CHECK_EN_BIT] = o_check_en;
      REG_GOOD_CNT: o_apb.prdata = good_cnt;
      REG_DROP_CNT: o_apb.prdata = drop_cnt;
      default:      o_apb.prdata = '0;
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_check_en <= 1'b1;
      o_clear    <= 1'b0;
    end else begin
      // Clear lasts exactly one cycle after the write
      o_clear <= ctrl_wr & i_apb.pwdata[CTRL_CLEAR_BIT];
      if (ctrl_wr) begin
        o_check_en <= i_apb.pwdata[CTRL_CHECK_EN_BIT];
      end
    end
  end

  // Counters wrap, clear wins over a same-cycle event
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      good_cnt <= '0;
      drop_cnt <= '0;
    end else if (o_clear) begin
      good_cnt <= '0;
      drop_cnt <= '0;
    end else begin
      good_cnt <= good_cnt + i_evt.good;
      drop_cnt <= drop_cnt + i_evt.bad;
    end
  end

endmodule : pkt_stats_csr

/* logic/pkt_filter_top.sv */
// Packet filter top level, checker into drop FIFO into output buffer, APB configured

`timescale 1ns/100ps

module pkt_filter_top #(
  parameter int DATA_W        = stream_pkg::DATA_W,
  parameter int MAX_PKT_BEATS = 16
) (
  input  logic                     clk,
  input  logic                     i_arst_n,
  input  csr_pkg::apb_req_t        i_apb,
  output csr_pkg::apb_rsp_t        o_apb,
  input  stream_pkg::stream_beat_t i_beat,
  input  logic                     i_valid,
  output logic                     o_ready,
  output stream_pkg::stream_beat_t o_beat,
  output logic                     o_valid,
  input  logic                     i_ready
);

  import stream_pkg::*;

  chk_beat_t    chk_beat;
  logic         chk_valid;
  logic         chk_ready;
  stream_beat_t fifo_beat;
  logic         fifo_valid;
  logic         fifo_ready;
  pkt_evt_t     pkt_evt;
  logic         check_en;
  logic         clear;

  pkt_check #(
    .DATA_W (DATA_W)
  ) u_check (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_clear    (clear),
    .i_check_en (check_en),
    .i_valid    (i_valid),
    .i_beat     (i_beat),
    .o_ready    (o_ready),
    .o_beat     (chk_beat),
    .o_valid    (chk_valid),
    .i_ready    (chk_ready),
    .o_evt      (pkt_evt)
  );

  pkt_drop_fifo #(
    .DATA_W        (DATA_W),
    .MAX_PKT_BEATS (MAX_PKT_BEATS)
  ) u_fifo (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_clear  (clear),
    .i_valid  (chk_valid),
    .i_beat   (chk_beat),
    .o_ready  (chk_ready),
    .o_beat   (fifo_beat),
    .o_valid  (fifo_valid),
    .i_ready  (fifo_ready)
  );

  stream_flop2 #(
    .T_PAYLOAD (stream_beat_t)
  ) u_out_buf (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_clear  (clear),
    .i_valid  (fifo_valid),
    .i_data   (fifo_beat),
    .o_ready  (fifo_ready),
    .o_data   (o_beat),
    .o_valid  (o_valid),
    .i_ready  (i_ready)
  );

  pkt_stats_csr u_csr (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_apb      (i_apb),
    .o_apb      (o_apb),
    .i_evt      (pkt_evt),
    .o_check_en (check_en),
    .o_clear    (clear)
  );

endmodule : pkt_filter_top

/* tb/tb_clkgen.sv */
// Testbench clock and reset source, instantiated once by the packet filter testbench
`timescale 1ns/100ps

module tb_clkgen #(
  parameter int CLK_PERIOD = 100,
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic o_arst_n
);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Reset released on a falling edge, away from the active edge
  initial begin
    o_arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    o_arst_n = 1'b1;
  end

endmodule : tb_clkgen

/* tb/tb_pkt_filter.sv */
// Self-checking testbench for the packet filter, random packets and stalls against a queue model
`timescale 1ns/100ps

module tb_pkt_filter;

  import stream_pkg::*;
  import csr_pkg::*;

  localparam int          CLK_PERIOD    = 100;
  localparam int          MAX_PKT_BEATS = 16;
  localparam int          NUM_PKTS      = 40;
  localparam int          NUM_PHASES    = 3;
  localparam int          STALL_FACTOR  = 8;
  localparam int          DRAIN_CYCLES  = 20;
  localparam logic [31:0] LFSR_SEED     = 32'hbb5a_9469;
  localparam logic [7:0]  REG_UNMAPPED  = 8'h0c;

  logic         clk;
  logic         arst_n;
  apb_req_t     apb_req;
  apb_rsp_t     apb_rsp;
  stream_beat_t in_beat;
  logic         in_valid;
  logic         in_ready;
  stream_beat_t out_beat;
  logic         out_valid;
  logic         out_ready;

  // Model state
  logic [31:0]  lfsr_state;
  stream_beat_t pkt_q[$];
  stream_beat_t exp_q[$];
  int unsigned  exp_good;
  int unsigned  exp_drop;
  logic         check_en_model;
  logic         saw_backpressure;

  tb_clkgen #(
    .CLK_PERIOD (CLK_PERIOD),
    .RST_CYCLES (3)
  ) u_clkgen (
    .clk      (clk),
    .o_arst_n (arst_n)
  );

  pkt_filter_top #(
    .DATA_W        (DATA_W),
    .MAX_PKT_BEATS (MAX_PKT_BEATS)
  ) u_dut (
    .clk      (clk),
    .i_arst_n (arst_n),
    .i_apb    (apb_req),
    .o_apb    (apb_rsp),
    .i_beat   (in_beat),
    .i_valid  (in_valid),
    .o_ready  (in_ready),
    .o_beat   (out_beat),
    .o_valid  (out_valid),
    .i_ready  (out_ready)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s mismatch, got %0h expected %0h",
               $time, what, actual, expected);
      $display("Test FAILED");
      $fatal(1, "check failed");
    end
  endtask

  // Builds the next packet and files it as passed or dropped by the checksum rule
  task automatic make_packet();
    logic [31:0]  len_bits;
    logic [31:0]  pick;
    logic [31:0]  word;
    logic [31:0]  acc;
    stream_beat_t beat;
    int           len;
    rand_bits(8, len_bits);
    len = int'(len_bits % MAX_PKT_BEATS) + 1;
    rand_bits(2, pick);
    acc = '0;
    for (int i = 0; i < len; i++) begin
      rand_bits(32, word);
      // Three in four packets close with the word that cancels the XOR
      if (i == len - 1 && pick != 0) begin
        word = acc;
      end
      acc       = acc ^ word;
      beat.data = word;
      beat.last = (i == len - 1);
      pkt_q.push_back(beat);
    end
    if (acc == '0 || !check_en_model) begin
      foreach (pkt_q[i]) exp_q.push_back(pkt_q[i]);
      exp_good++;
    end else begin
      exp_drop++;
    end
  endtask

  // Sends n_pkts packets and drains the output, higher stall_level means more stalls
  task automatic run_traffic(input int n_pkts, input int stall_level);
    int           sent;
    int           idle;
    logic         in_take;
    logic         hold;
    logic [31:0]  stall;
    stream_beat_t held_beat;
    stream_beat_t exp_beat;
    sent      = 0;
    idle      = 0;
    in_take   = 1'b0;
    hold      = 1'b0;
    held_beat = '0;
    while (idle < DRAIN_CYCLES) begin
      @(negedge clk);
      // Output side, a stalled beat must stay put
      if (hold) begin
        check_value(out_valid, 1'b1, "o_valid while stalled");
        check_value(out_beat, held_beat, "o_beat while stalled");
      end
      rand_bits(2, stall);
      out_ready = (stall >= stall_level);
      if (out_valid && exp_q.size() == 0) begin
        $display("Output presented a beat at %0t ns although no beat was expected", $time);
        $display("Test FAILED");
        $fatal(1, "unexpected beat");
      end else if (out_valid && out_ready) begin
        exp_beat = exp_q.pop_front();
        check_value(out_beat, exp_beat, "output beat {data,last}");
      end
      hold      = out_valid & ~out_ready;
      held_beat = out_beat;
      // Input side
      if (in_take) begin
        void'(pkt_q.pop_front());
      end
      if (pkt_q.size() == 0 && sent < n_pkts) begin
        make_packet();
        sent++;
      end
      if (pkt_q.size() != 0) begin
        in_valid = 1'b1;
        in_beat  = pkt_q[0];
      end else begin
        in_valid = 1'b0;
        in_beat  = '0;
      end
      in_take = in_valid & in_ready;
      if (in_valid && !in_ready) begin
        saw_backpressure = 1'b1;
      end
      if (sent == n_pkts && pkt_q.size() == 0 && exp_q.size() == 0) begin
        idle++;
      end
    end
  endtask

  // Called on a falling edge, returns on a falling edge with the bus idle
  task automatic apb_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #(CLK_PERIOD / 4);
    check_value(apb_rsp.pready, 1'b1, "APB pready");
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] wdata,
                           input logic exp_err);
    logic [31:0] rdata;
    logic        slverr;
    apb_access(1'b1, addr, wdata, rdata, slverr);
    check_value(slverr, exp_err, "APB write pslverr");
  endtask

  task automatic reg_read_check(input logic [7:0] addr, input logic [31:0] expected,
                                input string what);
    logic [31:0] rdata;
    logic        slverr;
    apb_access(1'b0, addr, '0, rdata, slverr);
    check_value(slverr, 1'b0, "APB read pslverr");
    check_value(rdata, expected, what);
  endtask

  task automatic counters_check();
    reg_read_check(REG_GOOD_CNT, exp_good, "good packet counter");
    reg_read_check(REG_DROP_CNT, exp_drop, "dropped packet counter");
  endtask

  initial begin
    logic [31:0] rdata;
    logic        slverr;
    apb_req          = '0;
    in_beat          = '0;
    in_valid         = 1'b0;
    out_ready        = 1'b0;
    lfsr_state       = LFSR_SEED;
    exp_good         = 0;
    exp_drop         = 0;
    check_en_model   = 1'b1;
    saw_backpressure = 1'b0;
    wait (arst_n === 1'b1);
    @(negedge clk);
    reg_read_check(REG_CTRL, 32'h1, "CTRL after reset");
    counters_check();

    // Checking on, light output stalls
    run_traffic(NUM_PKTS, 1);
    counters_check();

    // Heavy stalls, the FIFO must fill and push back on the input
    saw_backpressure = 1'b0;
    run_traffic(NUM_PKTS, 3);
    check_value(saw_backpressure, 1'b1, "input back-pressure under output stalls");
    counters_check();

    // Checking off, every packet passes
    reg_write(REG_CTRL, 32'h0, 1'b0);
    check_en_model = 1'b0;
    run_traffic(NUM_PKTS, 1);
    counters_check();

    // Clear with checking back on
    reg_write(REG_CTRL, 32'h3, 1'b0);
    check_en_model = 1'b1;
    exp_good       = 0;
    exp_drop       = 0;
    counters_check();
    reg_read_check(REG_CTRL, 32'h1, "CTRL after clear");

    // Unmapped address errors, and the write has no effect
    apb_access(1'b0, REG_UNMAPPED, '0, rdata, slverr);
    check_value(slverr, 1'b1, "pslverr on unmapped read");
    reg_write(REG_UNMAPPED, 32'h0, 1'b1);
    reg_read_check(REG_CTRL, 32'h1, "CTRL after unmapped write");

    $display("Test OK");
    $finish;
  end

  // Limit scales with the worst-case traffic of all phases
  initial begin
    #((NUM_PHASES * NUM_PKTS * MAX_PKT_BEATS * STALL_FACTOR + 500) * CLK_PERIOD);
    $display("Timeout: the traffic did not drain within the watchdog limit");
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule : tb_pkt_filter

/* flist.f */
logic/stream_pkg.sv
logic/csr_pkg.sv
logic/pkt_check.sv
logic/pkt_drop_fifo.sv
logic/stream_flop2.sv
logic/pkt_stats_csr.sv
logic/pkt_filter_top.sv
tb/tb_clkgen.sv
tb/tb_pkt_filter.sv

/* Bender.yml */
package:
  name: pkt_filter

sources:
  - logic/stream_pkg.sv
  - logic/csr_pkg.sv
  - logic/pkt_check.sv
  - logic/pkt_drop_fifo.sv
  - logic/stream_flop2.sv
  - logic/pkt_stats_csr.sv
  - logic/pkt_filter_top.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/tb_pkt_filter.sv
